// ==== Bender.yml ====
package:
  name: fpu

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fpu_pkg.sv
      - hdl/ks_adder.sv
      - hdl/fp_addsub.sv
      - hdl/booth_mul.sv
      - hdl/mant_divider.sv
      - hdl/fp_compare.sv
      - hdl/fpu_top.sv
  - target: test
    include_dirs:
      - hdl
      - sim
    files:
      - sim/tb_fpu.sv

// ==== hdl/booth_mul.sv ====
`timescale 1ns/1ns
`include "fpu_defs.svh"

module booth_mul import fpu_pkg::*; (
	input  fp_word_t i_a,
	input  fp_word_t i_b,
	output fp_word_t o_result,
	output logic     o_ovf,
	output logic     o_unf
);

	localparam int NGRP = `MANT_BITS / 2 + 1;   // radix-4 groups, last one holds the msb
	localparam int PW   = 2 * `MANT_BITS + 4;   // signed partial product width
	localparam int MSB  = 2 * `MANT_BITS - 1;
	localparam logic signed [9:0] EMAX = `EXP_MAX;
	localparam logic signed [9:0] BIAS = `EXP_BIAS;

	mant_t                     ma;
	mant_t                     mb;
	exp_t                      ea;
	exp_t                      eb;
	logic [2*NGRP:0]           b_rec;
	logic signed [PW-1:0]      a_ext;
	logic signed [PW-1:0]      pp [NGRP];
	logic signed [PW-1:0]      acc;
	logic [MSB:0]              prod;
	logic [`FRAC_BITS-1:0]     frac;
	logic signed [9:0]         exp_p;
	logic                      sign_p;

	assign ma = {1'b1, i_a[`FRAC_BITS-1:0]};
	assign mb = {1'b1, i_b[`FRAC_BITS-1:0]};
	assign ea = i_a[`FP_WIDTH-2 -: `EXP_BITS];
	assign eb = i_b[`FP_WIDTH-2 -: `EXP_BITS];

	assign b_rec = {2'b00, mb, 1'b0};   // zero below bit 0, unsigned top
	assign a_ext = $signed({{(PW-`MANT_BITS){1'b0}}, ma});

	// overlapping triplets pick 0, +-a or +-2a
	always_comb begin
		for (int j = 0; j < NGRP; j++) begin
			case (b_rec[2*j +: 3])
				3'b001, 3'b010: pp[j] = a_ext;
				3'b011:         pp[j] = a_ext <<< 1;
				3'b100:         pp[j] = -(a_ext <<< 1);
				3'b101, 3'b110: pp[j] = -a_ext;
				default:        pp[j] = '0;
			endcase
		end
	end

	always_comb begin
		acc = '0;
		for (int j = 0; j < NGRP; j++) begin
			acc = acc + (pp[j] <<< (2 * j));
		end
	end

	assign prod = acc[MSB:0];

	// product of two [1,2) significands lands in [1,4)
	assign frac  = prod[MSB] ? prod[MSB-1 -: `FRAC_BITS] : prod[MSB-2 -: `FRAC_BITS];
	assign exp_p = $signed({2'b00, ea}) + $signed({2'b00, eb}) - BIAS
		+ $signed({9'd0, prod[MSB]});
	assign sign_p = i_a[`FP_WIDTH-1] ^ i_b[`FP_WIDTH-1];

	assign o_result = {sign_p, exp_p[`EXP_BITS-1:0], frac};
	assign o_ovf    = exp_p > EMAX;
	assign o_unf    = exp_p < 10'sd1;

endmodule

// ==== hdl/fp_addsub.sv ====
`timescale 1ns/1ns
`include "fpu_defs.svh"

module fp_addsub import fpu_pkg::*; (
	input  fp_word_t i_a,
	input  fp_word_t i_b,
	input  logic     i_sub,
	output fp_word_t o_result,
	output logic     o_ovf,
	output logic     o_unf
);

	localparam int SW = `MANT_BITS + 1;                 // room for the add carry
	localparam logic signed [9:0] EMAX = `EXP_MAX;

	logic              sign_b;    // sign of b after the subtract flip
	logic              a_leads;
	logic              sign_l;
	logic              eff_sub;
	exp_t              exp_l;
	exp_t              exp_s;
	exp_t              exp_diff;
	mant_t             mant_l;
	mant_t             mant_s;
	mant_t             mant_al;
	logic [SW-1:0]     add_b;
	logic [SW-1:0]     sum;
	logic [4:0]        lzc;
	mant_t             mant_n;
	logic signed [9:0] exp_n;
	logic              is_zero;

	assign sign_b  = i_b[`FP_WIDTH-1] ^ i_sub;
	assign eff_sub = i_a[`FP_WIDTH-1] ^ sign_b;

	// exponent and fraction compare as one unsigned field
	assign a_leads = i_a[`FP_WIDTH-2:0] >= i_b[`FP_WIDTH-2:0];
	assign sign_l  = a_leads ? i_a[`FP_WIDTH-1] : sign_b;

	assign exp_l  = a_leads ? i_a[`FP_WIDTH-2 -: `EXP_BITS] : i_b[`FP_WIDTH-2 -: `EXP_BITS];
	assign exp_s  = a_leads ? i_b[`FP_WIDTH-2 -: `EXP_BITS] : i_a[`FP_WIDTH-2 -: `EXP_BITS];
	assign mant_l = {1'b1, a_leads ? i_a[`FRAC_BITS-1:0] : i_b[`FRAC_BITS-1:0]};
	assign mant_s = {1'b1, a_leads ? i_b[`FRAC_BITS-1:0] : i_a[`FRAC_BITS-1:0]};

	assign exp_diff = exp_l - exp_s;
	assign mant_al  = mant_s >> exp_diff;  // shifted-out bits dropped, 24+ clears it

	// one's complement plus carry in gives the two's complement subtrahend
	assign add_b = eff_sub ? ~{1'b0, mant_al} : {1'b0, mant_al};

	ks_adder #(
		.WIDTH (SW)
	) u_mag_add (
		.i_a    ({1'b0, mant_l}),
		.i_b    (add_b),
		.i_cin  (eff_sub),
		.o_sum  (sum),
		.o_cout ()            // add carry shows up in sum[SW-1]
	);

	always_comb begin
		lzc = 5'(`MANT_BITS);
		for (int i = 0; i < `MANT_BITS; i++) begin
			if (sum[i]) begin
				lzc = 5'(`MANT_BITS - 1 - i);
			end
		end
		is_zero = (sum == '0);
		if (sum[SW-1]) begin  // carry out of the add
			mant_n = sum[SW-1:1];
			exp_n  = $signed({2'b00, exp_l}) + 10'sd1;
		end else begin
			mant_n = mant_t'(sum[`MANT_BITS-1:0] << lzc);
			exp_n  = $signed({2'b00, exp_l}) - $signed({5'b00000, lzc});
		end
	end

	assign o_result = is_zero ? '0 :
		{sign_l, exp_n[`EXP_BITS-1:0], mant_n[`FRAC_BITS-1:0]};
	assign o_ovf = ~is_zero & (exp_n > EMAX);
	assign o_unf = ~is_zero & (exp_n < 10'sd1);

endmodule

// ==== hdl/fp_compare.sv ====
`timescale 1ns/1ns
`include "fpu_defs.svh"

module fp_compare import fpu_pkg::*; (
	input  fp_word_t i_a,
	input  fp_word_t i_b,
	output logic     o_greater,
	output logic     o_equal,
	output logic     o_less
);

	logic sa;
	logic sb;
	logic both_zero;  // +0 and -0
	logic mag_gt;
	logic mag_eq;

	assign sa        = i_a[`FP_WIDTH-1];
	assign sb        = i_b[`FP_WIDTH-1];
	assign both_zero = (i_a[`FP_WIDTH-2:0] == '0) && (i_b[`FP_WIDTH-2:0] == '0);
	assign mag_gt    = i_a[`FP_WIDTH-2:0] > i_b[`FP_WIDTH-2:0];
	assign mag_eq    = i_a[`FP_WIDTH-2:0] == i_b[`FP_WIDTH-2:0];

	always_comb begin
		o_greater = 1'b0;
		o_equal   = 1'b0;
		o_less    = 1'b0;
		if (both_zero || (sa == sb && mag_eq)) begin
			o_equal = 1'b1;
		end else if (sa != sb) begin
			o_greater = ~sa;
			o_less    = sa;
		end else begin
			// negative operands reverse the magnitude order
			o_greater = mag_gt ^ sa;
			o_less    = ~(mag_gt ^ sa);
		end
	end

endmodule

// ==== hdl/fpu_defs.svh ====
`ifndef FPU_DEFS_SVH
`define FPU_DEFS_SVH

// single precision word layout
`define FP_WIDTH 32
`define EXP_BITS 8
`define FRAC_BITS 23

// significand with the hidden one
`define MANT_BITS 24

// exponent range
`define EXP_BIAS 127
`define EXP_MAX 254

// quotient bits from the divider
`define DIV_ITER 25

`endif

// ==== hdl/fpu_pkg.sv ====
package fpu_pkg;

	`include "fpu_defs.svh"

	typedef logic [`FP_WIDTH-1:0] fp_word_t;  // sign, exponent, fraction
	typedef logic [`EXP_BITS-1:0] exp_t;      // biased exponent
	typedef logic [`MANT_BITS-1:0] mant_t;    // hidden one included

	// 5 to 7 are illegal and give an all-zero result
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_MUL = 3'd2,
		OP_DIV = 3'd3,
		OP_CMP = 3'd4
	} fpu_op_e;

	typedef enum logic [1:0] {
		DIV_IDLE = 2'd0,
		DIV_RUN  = 2'd1,
		DIV_DONE = 2'd2
	} div_state_e;

endpackage

// ==== hdl/fpu_top.sv ====
`timescale 1ns/1ns

module fpu_top import fpu_pkg::*; (
	input  logic     clk,
	input  logic     i_rst_n,
	input  logic     i_valid,
	output logic     o_ready,
	input  fpu_op_e  i_op,
	input  fp_word_t i_a,
	input  fp_word_t i_b,
	output logic     o_valid,
	input  logic     i_ready,
	output fp_word_t o_result,
	output logic     o_ovf,
	output logic     o_unf,
	output logic     o_dbz,
	output logic     o_greater,
	output logic     o_equal,
	output logic     o_less
);

	fpu_op_e    op_q;
	fp_word_t   a_q;
	fp_word_t   b_q;
	logic       pend;       // operands held, unit output due next edge
	logic       accept;
	logic       load;
	logic       div_start;
	fp_word_t   as_result;
	fp_word_t   mul_result;
	fp_word_t   div_result;
	logic       as_ovf;
	logic       as_unf;
	logic       mul_ovf;
	logic       mul_unf;
	logic       div_ovf;
	logic       div_unf;
	logic       div_dbz;
	logic       div_done;
	div_state_e div_state;
	logic       cmp_gt;
	logic       cmp_eq;
	logic       cmp_lt;
	fp_word_t   nxt_result;
	logic [5:0] nxt_flags;  // ovf, unf, dbz, greater, equal, less

	// ready looks at the result register as it will be after this edge
	assign o_ready   = ~pend && (div_state == DIV_IDLE) && (~o_valid || i_ready);
	assign accept    = i_valid && o_ready;
	assign div_start = pend && (op_q == OP_DIV);
	assign load      = (pend && op_q != OP_DIV) || div_done;

	fp_addsub u_addsub (
		.i_a      (a_q),
		.i_b      (b_q),
		.i_sub    (op_q == OP_SUB),
		.o_result (as_result),
		.o_ovf    (as_ovf),
		.o_unf    (as_unf)
	);

	booth_mul u_mul (
		.i_a      (a_q),
		.i_b      (b_q),
		.o_result (mul_result),
		.o_ovf    (mul_ovf),
		.o_unf    (mul_unf)
	);

	mant_divider u_div (
		.clk      (clk),
		.i_rst_n  (i_rst_n),
		.i_start  (div_start),
		.i_a      (a_q),
		.i_b      (b_q),
		.o_done   (div_done),
		.o_result (div_result),
		.o_ovf    (div_ovf),
		.o_unf    (div_unf),
		.o_dbz    (div_dbz),
		.o_state  (div_state)
	);

	fp_compare u_cmp (
		.i_a       (a_q),
		.i_b       (b_q),
		.o_greater (cmp_gt),
		.o_equal   (cmp_eq),
		.o_less    (cmp_lt)
	);

	always_comb begin
		nxt_result = '0;
		nxt_flags  = '0;
		case (op_q)
			OP_ADD, OP_SUB: begin
				nxt_result = as_result;
				nxt_flags  = {as_ovf, as_unf, 4'b0000};
			end
			OP_MUL: begin
				nxt_result = mul_result;
				nxt_flags  = {mul_ovf, mul_unf, 4'b0000};
			end
			OP_DIV: begin
				nxt_result = div_result;
				nxt_flags  = {div_ovf, div_unf, div_dbz, 3'b000};
			end
			OP_CMP: nxt_flags = {3'b000, cmp_gt, cmp_eq, cmp_lt};
			default: ;  // illegal opcode, everything zero
		endcase
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			pend    <= 1'b0;
			o_valid <= 1'b0;
		end else begin
			pend <= accept;
			if (load) begin
				o_valid <= 1'b1;
			end else if (i_ready) begin
				o_valid <= 1'b0;  // consumed
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			op_q <= i_op;
			a_q  <= i_a;
			b_q  <= i_b;
		end
		if (load) begin
			o_result <= nxt_result;
			{o_ovf, o_unf, o_dbz, o_greater, o_equal, o_less} <= nxt_flags;
		end
	end

endmodule

// ==== hdl/ks_adder.sv ====
`timescale 1ns/1ns
`include "fpu_defs.svh"

module ks_adder #(
	parameter int WIDTH = `MANT_BITS
) (
	input  logic [WIDTH-1:0] i_a,
	input  logic [WIDTH-1:0] i_b,
	input  logic             i_cin,
	output logic [WIDTH-1:0] o_sum,
	output logic             o_cout
);

	localparam int LEVELS = $clog2(WIDTH);

	wire [WIDTH-1:0] hs;              // half sum, also the level 0 propagate
	wire [WIDTH-1:0] g [0:LEVELS];    // group generate per level
	wire [WIDTH-1:0] p [0:LEVELS];    // group propagate per level

	assign hs = i_a ^ i_b;
	assign p[0] = hs;
	// carry in folded into bit 0 so g at the top level is the carry out of each bit
	assign g[0] = (i_a & i_b) | {{(WIDTH-1){1'b0}}, hs[0] & i_cin};

	genvar l, k;
	generate
		for (l = 0; l < LEVELS; l++) begin : g_level
			localparam int D = 1 << l;
			for (k = 0; k < WIDTH; k++) begin : g_bit
				if (k >= 2 * D) begin : g_black
					assign g[l+1][k] = g[l][k] | (p[l][k] & g[l][k-D]);
					assign p[l+1][k] = p[l][k] & p[l][k-D];
				end else if (k >= D) begin : g_gray
					// span reaches bit 0 here, generate is final
					assign g[l+1][k] = g[l][k] | (p[l][k] & g[l][k-D]);
					assign p[l+1][k] = p[l][k];
				end else begin : g_pass
					assign g[l+1][k] = g[l][k];
					assign p[l+1][k] = p[l][k];
				end
			end
		end
	endgenerate

	generate
		if (WIDTH > 1) begin : g_sum_wide
			assign o_sum = hs ^ {g[LEVELS][WIDTH-2:0], i_cin};
		end else begin : g_sum_bit
			assign o_sum = hs ^ i_cin;
		end
	endgenerate

	assign o_cout = g[LEVELS][WIDTH-1];

endmodule

// ==== hdl/mant_divider.sv ====
`timescale 1ns/1ns
`include "fpu_defs.svh"

module mant_divider import fpu_pkg::*; (
	input  logic       clk,
	input  logic       i_rst_n,
	input  logic       i_start,
	input  fp_word_t   i_a,
	input  fp_word_t   i_b,
	output logic       o_done,
	output fp_word_t   o_result,
	output logic       o_ovf,
	output logic       o_unf,
	output logic       o_dbz,
	output div_state_e o_state
);

	localparam int RW    = `MANT_BITS + 1;         // remainder stays below 2*divisor
	localparam int CNT_W = $clog2(`DIV_ITER);
	localparam logic signed [9:0] EMAX = `EXP_MAX;
	localparam logic signed [9:0] BIAS = `EXP_BIAS;

	div_state_e        state;
	logic [CNT_W-1:0]  cnt;
	logic [RW-1:0]     rem;
	logic [RW-1:0]     diff;
	logic              fits;        // no borrow from rem - divisor
	logic [RW-1:0]     quot;
	mant_t             mb;
	exp_t              ea;
	exp_t              eb;
	logic              sgn;
	logic              dbz;
	logic              b_zero;
	logic signed [9:0] exp_q;

	assign b_zero = (i_b[`FP_WIDTH-2:0] == '0);

	ks_adder #(
		.WIDTH (RW)
	) u_trial (
		.i_a    (rem),
		.i_b    (~{1'b0, mb}),
		.i_cin  (1'b1),
		.o_sum  (diff),
		.o_cout (fits)
	);

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			state <= DIV_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				DIV_IDLE: begin
					if (i_start) begin
						state <= b_zero ? DIV_DONE : DIV_RUN;
						cnt   <= '0;
					end
				end
				DIV_RUN: begin
					cnt <= cnt + 1'b1;
					if (cnt == CNT_W'(`DIV_ITER - 1)) begin
						state <= DIV_DONE;
					end
				end
				default: state <= DIV_IDLE;  // done lasts one cycle
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == DIV_IDLE && i_start) begin
			rem  <= {1'b0, 1'b1, i_a[`FRAC_BITS-1:0]};
			mb   <= {1'b1, i_b[`FRAC_BITS-1:0]};
			quot <= '0;
			ea   <= i_a[`FP_WIDTH-2 -: `EXP_BITS];
			eb   <= i_b[`FP_WIDTH-2 -: `EXP_BITS];
			sgn  <= i_a[`FP_WIDTH-1] ^ i_b[`FP_WIDTH-1];
			dbz  <= b_zero;
		end else if (state == DIV_RUN) begin
			quot <= {quot[RW-2:0], fits};  // msb first
			rem  <= fits ? {diff[RW-2:0], 1'b0} : {rem[RW-2:0], 1'b0};
		end
	end

	assign exp_q = $signed({2'b00, ea}) - $signed({2'b00, eb}) + BIAS - 10'sd1
		+ $signed({9'd0, quot[RW-1]});

	assign o_done   = (state == DIV_DONE);
	assign o_state  = state;
	assign o_dbz    = dbz;
	assign o_result = dbz ? '0 : {sgn, exp_q[`EXP_BITS-1:0],
		quot[RW-1] ? quot[RW-2:1] : quot[RW-3:0]};
	assign o_ovf = ~dbz & (exp_q > EMAX);
	assign o_unf = ~dbz & (exp_q < 10'sd1);

endmodule

// ==== sim/tb_fpu_model.svh ====
`ifndef TB_FPU_MODEL_SVH
`define TB_FPU_MODEL_SVH

// flags come back as {ovf, unf, dbz, greater, equal, less}

function automatic logic [31:0] xorshift32(input logic [31:0] s);
	s ^= s << 13;
	s ^= s >> 17;
	s ^= s << 5;
	return s;
endfunction

function automatic void model_addsub(input fp_word_t x, input fp_word_t y, input logic sub,
		output fp_word_t r, output logic [5:0] fl);
	logic sy;
	logic x_leads;
	int el, es, ml, ms, sum, e;
	sy = y[31] ^ sub;
	x_leads = x[30:0] >= y[30:0];  // larger magnitude leads
	el = x_leads ? int'(x[30:23]) : int'(y[30:23]);
	es = x_leads ? int'(y[30:23]) : int'(x[30:23]);
	ml = x_leads ? int'({1'b1, x[22:0]}) : int'({1'b1, y[22:0]});
	ms = x_leads ? int'({1'b1, y[22:0]}) : int'({1'b1, x[22:0]});
	ms = (el - es >= 25) ? 0 : ms >> (el - es);
	sum = (x[31] == sy) ? ml + ms : ml - ms;
	r = '0;
	fl = '0;
	if (sum != 0) begin
		e = el;
		if (sum >= (1 << 24)) begin
			sum = sum >> 1;  // carry out
			e = e + 1;
		end else begin
			while (sum < (1 << 23)) begin
				sum = sum << 1;
				e = e - 1;
			end
		end
		r = {x_leads ? x[31] : sy, e[7:0], sum[22:0]};
		fl = {e > `EXP_MAX, e < 1, 4'b0000};
	end
endfunction

function automatic void model_mul(input fp_word_t x, input fp_word_t y,
		output fp_word_t r, output logic [5:0] fl);
	logic [47:0] ma, mb, p;
	int e;
	ma = {1'b1, x[22:0]};
	mb = {1'b1, y[22:0]};
	p = ma * mb;
	e = int'(x[30:23]) + int'(y[30:23]) - (p[47] ? 126 : 127);
	r = {x[31] ^ y[31], e[7:0], p[47] ? p[46:24] : p[45:23]};
	fl = {e > `EXP_MAX, e < 1, 4'b0000};
endfunction

function automatic void model_div(input fp_word_t x, input fp_word_t y,
		output fp_word_t r, output logic [5:0] fl);
	logic [47:0] num, den, q;
	int e;
	if (y[30:0] == '0) begin
		r = '0;
		fl = 6'b001000;
	end else begin
		num = {1'b1, x[22:0], 24'd0};
		den = {1'b1, y[22:0]};
		q = num / den;  // 25 significant bits
		e = int'(x[30:23]) - int'(y[30:23]) + (q[24] ? 127 : 126);
		r = {x[31] ^ y[31], e[7:0], q[24] ? q[23:1] : q[22:0]};
		fl = {e > `EXP_MAX, e < 1, 4'b0000};
	end
endfunction

function automatic void model_cmp(input fp_word_t x, input fp_word_t y,
		output fp_word_t r, output logic [5:0] fl);
	longint kx, ky;
	kx = x[30:0];
	ky = y[30:0];
	if (x[31]) kx = -kx;  // -0 folds onto +0
	if (y[31]) ky = -ky;
	r = '0;
	fl = {3'b000, kx > ky, kx == ky, kx < ky};
endfunction

function automatic void model_op(input fpu_op_e o, input fp_word_t x, input fp_word_t y,
		output fp_word_t r, output logic [5:0] fl);
	r = '0;
	fl = '0;
	case (o)
		OP_ADD: model_addsub(x, y, 1'b0, r, fl);
		OP_SUB: model_addsub(x, y, 1'b1, r, fl);
		OP_MUL: model_mul(x, y, r, fl);
		OP_DIV: model_div(x, y, r, fl);
		OP_CMP: model_cmp(x, y, r, fl);
		default: ;  // illegal opcode stays all zero
	endcase
endfunction

`endif

// ==== sim/tb_fpu.sv ====
`timescale 1ns/1ns
`include "fpu_defs.svh"

module tb_fpu import fpu_pkg::*; ();

	localparam int WAIT_LIMIT = 64;  // well above DIV_ITER + 2

	logic     clk = 1'b0;
	logic     rst_n;
	logic     valid;
	logic     ready;
	fpu_op_e  op;
	fp_word_t a;
	fp_word_t b;
	logic     res_valid;
	logic     res_ready;
	fp_word_t result;
	logic     ovf;
	logic     unf;
	logic     dbz;
	logic     gt;
	logic     eq;
	logic     lt;

	logic [31:0] rng = 32'd82;
	int checks = 0;
	int errors = 0;
	int timeouts = 0;

	`include "tb_fpu_model.svh"

	fpu_top DUT (
		.clk       (clk),
		.i_rst_n   (rst_n),
		.i_valid   (valid),
		.o_ready   (ready),
		.i_op      (op),
		.i_a       (a),
		.i_b       (b),
		.o_valid   (res_valid),
		.i_ready   (res_ready),
		.o_result  (result),
		.o_ovf     (ovf),
		.o_unf     (unf),
		.o_dbz     (dbz),
		.o_greater (gt),
		.o_equal   (eq),
		.o_less    (lt)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	function automatic fp_word_t random_operand(input int emin, input int emax, input logic sgn);
		logic [31:0] r;
		r = next_rand();
		return {sgn, 8'(emin + int'(r[31:24]) % (emax - emin + 1)), r[22:0]};
	endfunction

	task automatic compare_word(input string name, input fp_word_t exp_v, input fp_word_t act_v);
		checks++;
		if (exp_v !== act_v) begin
			errors++;
			$display("Error at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
		end
	endtask

	task automatic compare_flag(input string name, input logic exp_v, input logic act_v);
		checks++;
		if (exp_v !== act_v) begin
			errors++;
			$display("Error at %0t ns: %s expected %b, got %b", $time, name, exp_v, act_v);
		end
	endtask

	task automatic compare_state(input string name, input div_state_e exp_v,
			input div_state_e act_v);
		checks++;
		if (exp_v !== act_v) begin
			errors++;
			$display("Error at %0t ns: %s expected %s, got %s", $time, name,
				exp_v.name(), act_v.name());
		end
	endtask

	// holds valid until the DUT takes the operation
	task automatic issue(input fpu_op_e o, input fp_word_t x, input fp_word_t y);
		int n;
		@(posedge clk);
		valid <= 1'b1;
		op <= o;
		a <= x;
		b <= y;
		@(posedge clk);
		n = 1;
		while (!ready && n < WAIT_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (!ready) begin
			timeouts++;
			$display("Timeout: operation %s was never accepted", o.name());
		end
		valid <= 1'b0;
	endtask

	task automatic wait_result();
		int n;
		div_state_e st;
		@(posedge clk);
		n = 1;
		while (!res_valid && n < WAIT_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (!res_valid) begin
			st = DUT.u_div.o_state;
			timeouts++;
			$display("Timeout: no result after %0d cycles, divider in %s", n, st.name());
		end
	endtask

	task automatic check_outputs(input fp_word_t e_res, input logic [5:0] e_fl);
		compare_word("o_result", e_res, result);
		compare_flag("o_ovf", e_fl[5], ovf);
		compare_flag("o_unf", e_fl[4], unf);
		compare_flag("o_dbz", e_fl[3], dbz);
		compare_flag("o_greater", e_fl[2], gt);
		compare_flag("o_equal", e_fl[1], eq);
		compare_flag("o_less", e_fl[0], lt);
	endtask

	task automatic run_check(input fpu_op_e o, input fp_word_t x, input fp_word_t y);
		fp_word_t e_res;
		logic [5:0] e_fl;
		model_op(o, x, y, e_res, e_fl);
		issue(o, x, y);
		wait_result();
		check_outputs(e_res, e_fl);
	endtask

	task automatic test_reset();
		compare_flag("o_valid", 1'b0, res_valid);
		compare_flag("o_ready", 1'b1, ready);
		compare_state("u_div.o_state", DIV_IDLE, DUT.u_div.o_state);
		run_check(fpu_op_e'(3'd6), 32'h3F80_0000, 32'h4000_0000);
	endtask

	task automatic test_addsub();
		fp_word_t x;
		fp_word_t y;
		fpu_op_e o;
		for (int i = 0; i < 8; i++) begin
			x = random_operand(100, 140, next_rand() & 1);
			y = random_operand(100, 140, x[31] ^ i[1]);  // sign of y follows x on passes 0, 1, 4, 5
			if (i % 2 == 1) begin
				o = OP_SUB;
			end else begin
				o = OP_ADD;
			end
			run_check(o, x, y);
		end
		run_check(OP_SUB, x, x);  // exact cancellation
		run_check(OP_ADD, random_operand(150, 150, 0), random_operand(110, 110, 1));
		run_check(OP_ADD, random_operand(254, 254, 0), random_operand(254, 254, 0));
	endtask

	task automatic test_mul();
		for (int i = 0; i < 6; i++) begin
			run_check(OP_MUL, random_operand(100, 150, next_rand() & 1),
				random_operand(100, 150, next_rand() & 1));
		end
		run_check(OP_MUL, random_operand(20, 30, 0), random_operand(20, 30, 1));  // underflow
		run_check(OP_MUL, random_operand(200, 220, 1), random_operand(200, 220, 0));
	endtask

	task automatic test_div();
		fp_word_t x, y;
		logic [22:0] fa, fb;
		for (int i = 0; i < 6; i++) begin
			x = random_operand(110, 140, next_rand() & 1);
			y = random_operand(110, 140, next_rand() & 1);
			fa = x[22:0];
			fb = y[22:0];
			if ((i % 2 == 0) != (fa >= fb)) begin
				x[22:0] = fb;  // even passes want ma >= mb
				y[22:0] = fa;
			end
			run_check(OP_DIV, x, y);
		end
		run_check(OP_DIV, x, 32'h8000_0000);  // zero divisor
		@(posedge clk);
		compare_state("u_div.o_state", DIV_IDLE, DUT.u_div.o_state);
	endtask

	task automatic test_cmp();
		run_check(OP_CMP, 32'h3F80_0000, 32'hC000_0000);
		run_check(OP_CMP, 32'hBF80_0000, 32'h4000_0000);
		run_check(OP_CMP, 32'h4000_0000, 32'h4000_0000);
		run_check(OP_CMP, 32'h0000_0000, 32'h8000_0000);  // +0 against -0
		run_check(OP_CMP, 32'hC080_0000, 32'hBF00_0000);
		run_check(OP_CMP, 32'hBF00_0000, 32'hC080_0000);
	endtask

	task automatic test_backpressure();
		fp_word_t x, y, e_res, held;
		logic [5:0] e_fl;
		int hold;
		x = random_operand(120, 135, 0);
		y = random_operand(120, 135, 1);
		model_op(OP_DIV, x, y, e_res, e_fl);
		hold = 3 + int'(next_rand() % 16);
		res_ready <= 1'b0;
		issue(OP_DIV, x, y);
		wait_result();
		held = result;
		repeat (hold) begin
			@(posedge clk);
			compare_word("o_result", held, result);
			compare_flag("o_valid", 1'b1, res_valid);
			compare_flag("o_ready", 1'b0, ready);
		end
		check_outputs(e_res, e_fl);
		res_ready <= 1'b1;
		run_check(OP_ADD, random_operand(120, 130, 0), random_operand(120, 130, 0));
	endtask

	initial begin
		rst_n = 1'b0;
		valid = 1'b0;
		op = OP_ADD;
		a = '0;
		b = '0;
		res_ready = 1'b1;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		test_reset();
		test_addsub();
		test_mul();
		test_div();
		test_cmp();
		test_backpressure();
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+hdl
+incdir+sim
hdl/fpu_pkg.sv
hdl/ks_adder.sv
hdl/fp_addsub.sv
hdl/booth_mul.sv
hdl/mant_divider.sv
hdl/fp_compare.sv
hdl/fpu_top.sv
sim/tb_fpu.sv
